//--- src.f
+incdir+source
source/accum_pkg.sv
source/lane_pair_accum.sv
source/accum_sequencer.sv
source/multi_lane_accum.sv
testbench/tb_multi_lane_accum.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f src.f \
    --top-module tb_multi_lane_accum \
    -o Vtb_multi_lane_accum

out=$(./obj_dir/Vtb_multi_lane_accum)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

//--- testbench/tb_multi_lane_accum.sv
`include "accum_cfg.svh"

module tb_multi_lane_accum;

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////
    // DUT signals and bookkeeping
    ////////////////////////////////////////////////////////////

    logic                    sys_clk;
    logic                    sys_rst_n = 1'b0;
    logic                    accu_en = 1'b0;
    logic [`ACCUM_LANES-1:0] lane_valid = '0;
    accum_pkg::data_t        lane_data [`ACCUM_LANES] = '{default: '0};
    logic [`ACCUM_LANES-1:0] lane_ready;
    logic                    result_valid;
    accum_pkg::data_t        result_data;
    logic                    result_ready = 1'b0;
    logic                    accu_finished;

    accum_pkg::data_t        lane_words [`ACCUM_LANES][$];    // header followed by data
    int                      lane_pos [`ACCUM_LANES] = '{default: 0};
    logic [`ACCUM_LANES-1:0] xfer_seen = '0;                  // handshakes of last cycle
    logic                    lanes_on = 1'b0;
    logic                    stall_on = 1'b0;
    logic                    backpressure_on = 1'b0;
    logic                    expect_result = 1'b0;
    logic                    run_busy = 1'b0;                 // started and not yet accepted
    logic                    held_valid = 1'b0;
    logic                    after_accept = 1'b0;
    accum_pkg::data_t        held_data = '0;
    accum_pkg::data_t        expected_sum = '0;
    integer                  seed = 32'hc3bd7a88;
    int                      result_count = 0;
    int                      error_count = 0;
    int                      test_count = 0;
    int                      failed_tests = 0;
    int                      cycle_count = 0;
    int                      test_start = 0;
    int                      test_limit = 400;            // covers reset
    string                   test_name = "reset";

    initial begin
        sys_clk = 1'b0;
        forever begin
            #50 sys_clk = ~sys_clk;
        end
    end

    multi_lane_accum dut_i (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .accu_en       (accu_en),
        .lane_valid_0  (lane_valid[0]),
        .lane_data_0   (lane_data[0]),
        .lane_ready_0  (lane_ready[0]),
        .lane_valid_1  (lane_valid[1]),
        .lane_data_1   (lane_data[1]),
        .lane_ready_1  (lane_ready[1]),
        .lane_valid_2  (lane_valid[2]),
        .lane_data_2   (lane_data[2]),
        .lane_ready_2  (lane_ready[2]),
        .lane_valid_3  (lane_valid[3]),
        .lane_data_3   (lane_data[3]),
        .lane_ready_3  (lane_ready[3]),
        .result_valid  (result_valid),
        .result_data   (result_data),
        .result_ready  (result_ready),
        .accu_finished (accu_finished)
    );

    ////////////////////////////////////////////////////////////
    // reference and compare tasks
    ////////////////////////////////////////////////////////////

    // words holds every lane in order with its header first
    function automatic accum_pkg::data_t calc_expected_sum(input int lens [`ACCUM_LANES],
                                                           input accum_pkg::data_t words [$]);
        accum_pkg::data_t sum;
        int               idx;
        sum = '0;
        idx = 0;
        for (int n = 0; n < `ACCUM_LANES; n++) begin
            idx = idx + 1;                                  // skip header
            for (int k = 0; k < lens[n]; k++) begin
                sum = sum + words[idx];                     // wraps at 64 bits
                idx = idx + 1;
            end
        end
        return sum;
    endfunction

    task automatic report_failure(input string msg);
        $display("%0d ns: %s", $time, msg);
        error_count = error_count + 1;
    endtask

    task automatic check_sum(input string msg, input accum_pkg::data_t got,
                             input accum_pkg::data_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s, got %0d, expected %0d", $time, msg, got, exp);
            error_count = error_count + 1;
        end
    endtask

    task automatic check_flag(input string msg, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s, got %b, expected %b", $time, msg, got, exp);
            error_count = error_count + 1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // lane and result drivers
    ////////////////////////////////////////////////////////////

    always @(posedge sys_clk) begin
        for (int n = 0; n < `ACCUM_LANES; n++) begin
            if (xfer_seen[n]) begin
                lane_pos[n] = lane_pos[n] + 1;
            end
            if (!lanes_on || lane_pos[n] >= lane_words[n].size()) begin
                lane_valid[n] <= 1'b0;
            end else if (lane_valid[n] && !xfer_seen[n]) begin
                lane_valid[n] <= 1'b1;                      // hold until taken
            end else if (stall_on && ($unsigned($random(seed)) % 4 == 0)) begin
                lane_valid[n] <= 1'b0;                      // idle cycle
            end else begin
                lane_valid[n] <= 1'b1;
                lane_data[n]  <= lane_words[n][lane_pos[n]];
            end
        end
        if (backpressure_on) begin
            result_ready <= ($unsigned($random(seed)) % 3) != 0;
        end else begin
            result_ready <= 1'b1;
        end
    end

    // handshakes sampled mid-cycle where everything is settled
    always @(negedge sys_clk) begin
        for (int n = 0; n < `ACCUM_LANES; n++) begin
            xfer_seen[n] = lane_valid[n] && lane_ready[n];
            if (lanes_on && lane_pos[n] >= lane_words[n].size() && lane_ready[n]) begin
                report_failure($sformatf("lane %0d still ready after its last beat", n));
            end
        end
    end

    // result compare
    always @(negedge sys_clk) begin
        if (after_accept) begin
            check_flag("accu_finished after result accepted", accu_finished, 1'b1);
            check_flag("result_valid after result accepted", result_valid, 1'b0);
        end
        if (held_valid && result_valid) begin
            check_sum("result_data changed while held", result_data, held_data);
        end
        if (run_busy) begin
            check_flag("accu_finished during the run", accu_finished, 1'b0);
        end
        if (result_valid) begin
            if (!expect_result) begin
                report_failure("a result beat appeared with no run pending");
            end
        end
        if (result_valid && result_ready) begin
            check_sum("result_data against reference", result_data, expected_sum);
            result_count = result_count + 1;
            run_busy     = 1'b0;
        end
        after_accept = result_valid && result_ready;
        held_valid   = result_valid && !result_ready;
        held_data    = result_data;
    end

    always @(posedge sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count - test_start > test_limit) begin
            $display("timeout: test %s did not finish in %0d cycles", test_name, test_limit);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // test steps
    ////////////////////////////////////////////////////////////

    // called at a falling edge away from the driver's random draws
    task automatic load_streams(input int lens [`ACCUM_LANES], input bit neg_data);
        accum_pkg::data_t hdr;
        accum_pkg::data_t word;
        accum_pkg::data_t flat [$];
        int               total;
        total = 0;
        for (int n = 0; n < `ACCUM_LANES; n++) begin
            lane_words[n].delete();
            hdr = {$random(seed), $random(seed)};           // upper bits are ignored
            hdr[`ACCUM_LEN_W-1:0] = lens[n][`ACCUM_LEN_W-1:0];
            lane_words[n].push_back(hdr);
            flat.push_back(hdr);
            for (int k = 0; k < lens[n]; k++) begin
                word = {$random(seed), $random(seed)};
                if (neg_data) begin
                    word[`ACCUM_DATA_W-1] = 1'b1;
                end
                lane_words[n].push_back(word);
                flat.push_back(word);
            end
            lane_pos[n] = 0;
            total = total + lens[n] + 1;
        end
        expected_sum = calc_expected_sum(lens, flat);
        test_limit <= 20 * total + 200;
        test_start <= cycle_count;
    endtask

    task automatic start_run(input bit stall, input bit bp);
        @(posedge sys_clk);
        stall_on        <= stall;
        backpressure_on <= bp;
        lanes_on        <= 1'b1;
        accu_en         <= 1'b1;
        expect_result   = 1'b1;
        @(posedge sys_clk);
        @(negedge sys_clk);
        check_flag("accu_finished once the run starts", accu_finished, 1'b0);
        run_busy = 1'b1;
    endtask

    task automatic report_test(input string name, input int err_start);
        test_count = test_count + 1;
        if (error_count == err_start) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests = failed_tests + 1;
            $display("test %s: FAILED with %0d errors", name, error_count - err_start);
        end
    endtask

    task automatic run_accum(input string name, input int lens [`ACCUM_LANES],
                             input bit neg_data, input bit stall, input bit bp);
        int err_start;
        int start_count;
        err_start   = error_count;
        start_count = result_count;
        test_name   = name;
        @(negedge sys_clk);
        load_streams(lens, neg_data);
        start_run(stall, bp);
        while (result_count == start_count) begin
            @(posedge sys_clk);
        end
        expect_result = 1'b0;
        @(negedge sys_clk);
        for (int n = 0; n < `ACCUM_LANES; n++) begin
            if (lane_pos[n] != lane_words[n].size()) begin
                report_failure($sformatf("lane %0d has beats left untaken", n));
            end
        end
        repeat (2) @(posedge sys_clk);
        accu_en  <= 1'b0;
        lanes_on <= 1'b0;
        repeat (2) @(posedge sys_clk);
        report_test(name, err_start);
    endtask

    // drops accu_en part way through the data beats
    task automatic run_abort(input string name, input int lens [`ACCUM_LANES]);
        int err_start;
        int start_count;
        err_start   = error_count;
        start_count = result_count;
        test_name   = name;
        @(negedge sys_clk);
        load_streams(lens, 1'b0);
        start_run(1'b1, 1'b0);
        while (lane_pos[0] < 3) begin
            @(negedge sys_clk);
        end
        @(posedge sys_clk);
        accu_en       <= 1'b0;
        lanes_on      <= 1'b0;
        expect_result = 1'b0;
        run_busy      = 1'b0;
        repeat (2) @(posedge sys_clk);
        @(negedge sys_clk);
        check_flag("accu_finished after abort", accu_finished, 1'b1);
        check_flag("result_valid after abort", result_valid, 1'b0);
        repeat (6) @(posedge sys_clk);
        if (result_count != start_count) begin
            report_failure("a result was accepted after the run was aborted");
        end
        report_test(name, err_start);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int lens [`ACCUM_LANES];
        repeat (8) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        @(negedge sys_clk);
        check_flag("accu_finished after reset", accu_finished, 1'b1);
        check_flag("result_valid after reset", result_valid, 1'b0);
        check_flag("lane ready after reset", |lane_ready, 1'b0);

        lens = '{5, 5, 5, 5};
        run_accum("equal_lengths", lens, 1'b0, 1'b0, 1'b0);
        lens = '{1, 4, 0, 7};
        run_accum("unequal_lengths", lens, 1'b1, 1'b0, 1'b0);
        lens = '{0, 0, 0, 0};
        run_accum("zero_lengths", lens, 1'b0, 1'b0, 1'b0);

        for (int r = 0; r < 10; r++) begin
            @(negedge sys_clk);                         // keep random draws off the edge
            for (int n = 0; n < `ACCUM_LANES; n++) begin
                lens[n] = $unsigned($random(seed)) % 13;
            end
            run_accum($sformatf("random_%0d", r), lens, 1'b0, 1'b1, 1'b1);
        end

        lens = '{6, 6, 6, 6};
        run_abort("abort_mid_run", lens);
        run_accum("run_after_abort", lens, 1'b0, 1'b1, 1'b0);

        $display("tests run %0d, tests failed %0d, errors %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- source/multi_lane_accum.sv
`include "accum_cfg.svh"

module multi_lane_accum (
    input  logic             sys_clk,
    input  logic             sys_rst_n,
    input  logic             accu_en,

    input  logic             lane_valid_0,
    input  accum_pkg::data_t lane_data_0,
    output logic             lane_ready_0,

    input  logic             lane_valid_1,
    input  accum_pkg::data_t lane_data_1,
    output logic             lane_ready_1,

    input  logic             lane_valid_2,
    input  accum_pkg::data_t lane_data_2,
    output logic             lane_ready_2,

    input  logic             lane_valid_3,
    input  accum_pkg::data_t lane_data_3,
    output logic             lane_ready_3,

    output logic             result_valid,
    output accum_pkg::data_t result_data,
    input  logic             result_ready,

    output logic             accu_finished
);

    ////////////////////////////////////////////////////////////
    // lane bundles
    ////////////////////////////////////////////////////////////

    accum_pkg::lane_in_t [`ACCUM_LANES-1:0] lanes_all;
    logic [`ACCUM_LANES-1:0]                ready_all;

    accum_pkg::pair_status_t status_lo;
    accum_pkg::pair_status_t status_hi;

    logic header_take;
    logic data_take;
    logic clear;

    assign lanes_all[0] = '{valid: lane_valid_0, data: lane_data_0};
    assign lanes_all[1] = '{valid: lane_valid_1, data: lane_data_1};
    assign lanes_all[2] = '{valid: lane_valid_2, data: lane_data_2};
    assign lanes_all[3] = '{valid: lane_valid_3, data: lane_data_3};

    assign lane_ready_0 = ready_all[0];
    assign lane_ready_1 = ready_all[1];
    assign lane_ready_2 = ready_all[2];
    assign lane_ready_3 = ready_all[3];

    ////////////////////////////////////////////////////////////
    // lane pairs and sequencer
    ////////////////////////////////////////////////////////////

    lane_pair_accum pair_lo_i (                         // lanes 0 and 1
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .lanes       (lanes_all[1:0]),
        .header_take (header_take),
        .data_take   (data_take),
        .clear       (clear),
        .lane_ready  (ready_all[1:0]),
        .status      (status_lo)
    );

    lane_pair_accum pair_hi_i (                         // lanes 2 and 3
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .lanes       (lanes_all[3:2]),
        .header_take (header_take),
        .data_take   (data_take),
        .clear       (clear),
        .lane_ready  (ready_all[3:2]),
        .status      (status_hi)
    );

    accum_sequencer seq_i (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .accu_en       (accu_en),
        .pair_a        (status_lo),
        .pair_b        (status_hi),
        .result_ready  (result_ready),
        .header_take   (header_take),
        .data_take     (data_take),
        .clear         (clear),
        .result_valid  (result_valid),
        .result_data   (result_data),
        .accu_finished (accu_finished)
    );

endmodule

//--- source/accum_sequencer.sv
`include "accum_cfg.svh"

module accum_sequencer (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  logic                    accu_en,
    input  accum_pkg::pair_status_t pair_a,
    input  accum_pkg::pair_status_t pair_b,
    input  logic                    result_ready,
    output logic                    header_take,
    output logic                    data_take,
    output logic                    clear,
    output logic                    result_valid,
    output accum_pkg::data_t        result_data,
    output logic                    accu_finished
);

    ////////////////////////////////////////////////////////////
    // combined pair status
    ////////////////////////////////////////////////////////////

    accum_pkg::accum_state_t state_q;

    logic both_ready;
    logic both_done;
    logic load_result;

    assign both_ready = pair_a.ready_all && pair_b.ready_all;
    assign both_done  = pair_a.done_all && pair_b.done_all;

    // no beat moves once accu_en has dropped
    assign header_take = accu_en && (state_q == accum_pkg::HEADER) && both_ready;
    assign data_take   = accu_en && (state_q == accum_pkg::DATA) && both_ready
                         && !both_done;

    assign clear = !accu_en || (state_q == accum_pkg::IDLE);

    // partials are final one cycle after the last beat
    assign load_result = accu_en && (state_q == accum_pkg::DATA) && both_done;

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state_q       <= accum_pkg::IDLE;
            result_valid  <= 1'b0;
            accu_finished <= 1'b1;                      // idle reads as finished
        end else if (!accu_en) begin
            state_q       <= accum_pkg::IDLE;           // abort from any state
            result_valid  <= 1'b0;
            accu_finished <= 1'b1;
        end else begin
            case (state_q)
                accum_pkg::IDLE: begin
                    state_q       <= accum_pkg::HEADER;
                    accu_finished <= 1'b0;
                end

                accum_pkg::HEADER: begin
                    if (header_take) begin
                        state_q <= accum_pkg::DATA;
                    end
                end

                // zero lengths fall through here on the first cycle
                accum_pkg::DATA: begin
                    if (load_result) begin
                        state_q      <= accum_pkg::SEND;
                        result_valid <= 1'b1;
                    end
                end

                accum_pkg::SEND: begin
                    if (result_ready) begin
                        state_q       <= accum_pkg::DONE;
                        result_valid  <= 1'b0;
                        accu_finished <= 1'b1;
                    end
                end

                accum_pkg::DONE: begin
                    state_q <= accum_pkg::DONE;         // wait for accu_en low
                end

                default: begin
                    state_q       <= accum_pkg::IDLE;
                    result_valid  <= 1'b0;
                    accu_finished <= 1'b1;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // result register
    ////////////////////////////////////////////////////////////

    // loaded once per run, steady while SEND waits
    always_ff @(posedge sys_clk) begin
        if (load_result) begin
            result_data <= pair_a.partial + pair_b.partial;
        end
    end

endmodule

//--- source/lane_pair_accum.sv
`include "accum_cfg.svh"

module lane_pair_accum (
    input  logic                                             sys_clk,
    input  logic                                             sys_rst_n,
    input  accum_pkg::lane_in_t [`ACCUM_PAIR_LANES-1:0]      lanes,
    input  logic                                             header_take,
    input  logic                                             data_take,
    input  logic                                             clear,
    output logic [`ACCUM_PAIR_LANES-1:0]                     lane_ready,
    output accum_pkg::pair_status_t                          status
);

    ////////////////////////////////////////////////////////////
    // per-lane state
    ////////////////////////////////////////////////////////////

    accum_pkg::len_t   len_q [`ACCUM_PAIR_LANES];       // beats expected
    accum_pkg::len_t   cnt_q [`ACCUM_PAIR_LANES];       // beats taken so far
    logic              hdr_seen_q;                      // headers of this run captured
    accum_pkg::data_t  partial_q;

    logic [`ACCUM_PAIR_LANES-1:0] lane_done;
    logic [`ACCUM_PAIR_LANES-1:0] lane_ok;              // valid, or nothing left to take
    logic [`ACCUM_PAIR_LANES-1:0] lane_take;
    accum_pkg::data_t             take_sum;

    // before the header every lane still owes beats,
    // so header ready needs valid on both lanes
    always_comb begin
        for (int i = 0; i < `ACCUM_PAIR_LANES; i++) begin
            lane_done[i] = hdr_seen_q && (cnt_q[i] == len_q[i]);
            lane_ok[i]   = lanes[i].valid || lane_done[i];
            lane_take[i] = data_take && !lane_done[i];
        end
    end

    // ready only for lanes taken on this edge
    always_comb begin
        for (int i = 0; i < `ACCUM_PAIR_LANES; i++) begin
            lane_ready[i] = header_take || lane_take[i];
        end
    end

    // data of the lanes taken this cycle
    always_comb begin
        take_sum = '0;
        for (int i = 0; i < `ACCUM_PAIR_LANES; i++) begin
            if (lane_take[i]) begin
                take_sum = take_sum + lanes[i].data;    // wraps at data width
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // lengths and counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            hdr_seen_q <= 1'b0;
            for (int i = 0; i < `ACCUM_PAIR_LANES; i++) begin
                len_q[i] <= '0;
                cnt_q[i] <= '0;
            end
        end else if (clear) begin
            hdr_seen_q <= 1'b0;
            for (int i = 0; i < `ACCUM_PAIR_LANES; i++) begin
                len_q[i] <= '0;
                cnt_q[i] <= '0;
            end
        end else if (header_take) begin
            hdr_seen_q <= 1'b1;
            for (int i = 0; i < `ACCUM_PAIR_LANES; i++) begin
                len_q[i] <= lanes[i].data[`ACCUM_LEN_W-1:0];    // low bits only
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `ACCUM_PAIR_LANES; i++) begin
                if (lane_take[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // partial sum
    ////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (clear || header_take) begin
            partial_q <= '0;                            // header beat is not summed
        end else if (data_take) begin
            partial_q <= partial_q + take_sum;
        end
    end

    assign status.ready_all = &lane_ok;
    assign status.done_all  = &lane_done;
    assign status.partial   = partial_q;

endmodule

//--- source/accum_pkg.sv
`include "accum_cfg.svh"

package accum_pkg;

    ////////////////////////////////////////////////////////////
    // plain vector types
    ////////////////////////////////////////////////////////////

    typedef logic signed [`ACCUM_DATA_W-1:0] data_t;    // lane word, partial and total
    typedef logic [`ACCUM_LEN_W-1:0]         len_t;     // beats per lane

    ////////////////////////////////////////////////////////////
    // grouped signals
    ////////////////////////////////////////////////////////////

    // one input lane, ready travels the other way
    typedef struct packed {
        logic  valid;
        data_t data;
    } lane_in_t;

    // what a lane-pair unit reports to the sequencer
    typedef struct packed {
        logic  ready_all;                               // unfinished lanes all valid
        logic  done_all;                                // every count reached its length
        data_t partial;                                 // sum over both lanes
    } pair_status_t;

    ////////////////////////////////////////////////////////////
    // sequencer FSM
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,                                           // cleared, waiting for accu_en
        HEADER,                                         // one header beat per lane
        DATA,                                           // summing data beats
        SEND,                                           // result offered downstream
        DONE                                            // held until accu_en drops
    } accum_state_t;

endpackage

//--- source/accum_cfg.svh
`ifndef ACCUM_CFG_SVH
`define ACCUM_CFG_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

// lane word and running sum, wraps modulo 2^64
`define ACCUM_DATA_W        64

// beat count, taken from the low bits of the header beat
`define ACCUM_LEN_W         16

////////////////////////////////////////////////////////////
// lane layout
////////////////////////////////////////////////////////////

// each lane-pair unit serves this many lanes
`define ACCUM_PAIR_LANES    2

// lanes at the top level, two pairs
`define ACCUM_LANES         4

`endif
